//--- list.f
+incdir+testbench
rtl/host_proto_pkg.sv
rtl/user_io_pkg.sv
rtl/host_cmd_framer.sv
rtl/input_regs.sv
rtl/ps2_key_decoder.sv
rtl/file_download.sv
rtl/host_io_top.sv
testbench/host_io_tb.sv

//--- Bender.yml
package:
  name: host_io

sources:
  - target: any(rtl, test)
    files:
      - rtl/host_proto_pkg.sv
      - rtl/user_io_pkg.sv
      - rtl/host_cmd_framer.sv
      - rtl/input_regs.sv
      - rtl/ps2_key_decoder.sv
      - rtl/file_download.sv
      - rtl/host_io_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/host_io_tb.sv

//--- testbench/host_io_tb_util.svh
// random source, key event model and compare tasks, included inside the testbench module
`ifndef HOST_IO_TB_UTIL_SVH
`define HOST_IO_TB_UTIL_SVH

////////////////////////////////////////
// random bits
////////////////////////////////////////

// 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic next_bit();
	logic fb;
	fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] r;
	int          i;
	r = '0;
	for (i = 0; i < n; i++) r = {r[62:0], next_bit()};
	return r;
endfunction

////////////////////////////////////////
// key event model
////////////////////////////////////////

// raw holds the last four scan bytes, newest in the low byte
function automatic ps2_key_t expected_key(input logic [31:0] raw, input logic toggle);
	logic [7:0] newest;
	logic [7:0] second;
	logic [7:0] third;
	logic [9:0] body;
	newest = raw[7:0];
	second = raw[15:8];
	third  = raw[23:16];
	if (raw == 32'hE012E07C) body = 10'h37C;
	else if (raw == 32'h7CE0F012) body = 10'h17C;
	else if (raw == 32'hF014F077) body = 10'h377;
	else if (second == 8'hF0) body = {1'b0, third == 8'hE0, newest};
	else body = {1'b1, second == 8'hE0, newest};
	return {toggle, body};
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error: %s = %h, expected %h", name, got, exp);
	end
endtask

task automatic check_joystick(input string name, input joystick_t got, input joystick_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error: %s = %h, expected %h", name, got, exp);
	end
endtask

task automatic check_status(input string name, input status_t got, input status_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error: %s = %h, expected %h", name, got, exp);
	end
endtask

task automatic check_key(input string name, input ps2_key_t got, input ps2_key_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error: %s = %h, expected %h", name, got, exp);
	end
endtask

task automatic check_addr(input string name, input ioctl_addr_t got, input ioctl_addr_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Error: %s = %h, expected %h", name, got, exp);
	end
endtask

`endif

//--- testbench/host_io_tb.sv
// testbench for host_io_top, drives host commands and checks registers, keys and downloads
`timescale 1ns/100ps

module host_io_tb
	import host_proto_pkg::*;
	import user_io_pkg::*;
();

	localparam int data_width = 8;
	localparam int wait_limit = 200;
	localparam int dl_words   = 24;

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  io_enable;
	logic                  io_strobe;
	host_word_t            io_din;
	host_word_t            io_dout;
	logic                  io_wait;
	logic [1:0]            buttons;
	logic                  forced_scandoubler;
	logic                  direct_video;
	joystick_t             joystick_0;
	joystick_t             joystick_1;
	status_t               status;
	status_t               status_in;
	logic                  status_set;
	ps2_key_t              ps2_key;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	file_ext_t             ioctl_file_ext;
	ioctl_addr_t           ioctl_addr;
	logic [data_width-1:0] ioctl_dout;
	logic                  ioctl_wr;
	logic                  ioctl_wait;

	int          checks;
	int          errors;
	int          timeouts;
	int          wr_count;
	logic [31:0] lfsr_state;
	ps2_key_t    exp_key;
	host_word_t  tx_words[$];
	host_word_t  rx_words[$];
	logic [7:0]  exp_dl_data[$];

	`include "host_io_tb_util.svh"

	always #50 clk_sys = ~clk_sys;

	host_io_top #(
		.ioctl_data_width (data_width)
	) host_io_top_inst (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wr           (ioctl_wr),
		.ioctl_wait         (ioctl_wait)
	);

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		timeouts++;
		$display("Timeout: %s", what);
		finish_run();
	endtask

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_download(input logic level);
		int n;
		n = 0;
		while (ioctl_download !== level) begin
			step();
			n++;
			if (n > wait_limit) give_up("ioctl_download never reached the expected level");
		end
	endtask

	////////////////////////////////////////
	// host word driver
	////////////////////////////////////////

	task automatic send_word(input host_word_t w, input logic paced, output host_word_t rb);
		int n;
		n = 0;
		if (paced) begin
			// the core stalls at random, the host holds the word while io_wait is high
			ioctl_wait = next_bit();
			#1;
			check_word("io_wait", host_word_t'(io_wait), host_word_t'(ioctl_wait));
			while (io_wait) begin
				step();
				n++;
				if (n > wait_limit) give_up("io_wait stayed high before a data word");
				ioctl_wait = next_bit();
				#1;
				check_word("io_wait", host_word_t'(io_wait), host_word_t'(ioctl_wait));
			end
		end
		io_din    = w;
		io_strobe = 1'b1;
		step();
		io_strobe = 1'b0;
		rb        = io_dout;
		step();
	endtask

	// one framed command, code from the argument and data words from tx_words
	task automatic run_cmd(input host_word_t code);
		host_word_t rb;
		rx_words.delete();
		io_enable = 1'b1;
		step();
		send_word(code, 1'b0, rb);
		rx_words.push_back(rb);
		foreach (tx_words[i]) begin
			send_word(tx_words[i], code == cmd_file_data, rb);
			rx_words.push_back(rb);
		end
		io_enable = 1'b0;
		step();
		step();
		check_word("io_dout", io_dout, '0);
	endtask

	task automatic queue_bytes(input logic [63:0] seq, input int n);
		int i;
		tx_words.delete();
		for (i = n - 1; i >= 0; i--) tx_words.push_back({8'h00, seq[i*8 +: 8]});
	endtask

	task automatic key_command();
		logic [31:0] raw;
		logic        skipped;
		host_word_t  w;
		raw     = '0;
		skipped = 1'b0;
		foreach (tx_words[i]) begin
			w = tx_words[i];
			if (w[15:8] == skip_marker) skipped = 1'b1;
			else raw = {raw[23:0], w[7:0]};
		end
		run_cmd(cmd_keyboard);
		if (!skipped) exp_key = expected_key(raw, ~exp_key[10]);
		check_key("ps2_key", ps2_key, exp_key);
	endtask

	// download monitor, write data and address are stable around the falling edge
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr === 1'b1) begin
			if (exp_dl_data.size() == 0) begin
				errors++;
				$display("Write pulse seen with no data word outstanding");
			end else begin
				check_addr("ioctl_addr", ioctl_addr, ioctl_addr_t'(wr_count * (data_width / 8)));
				check_word("ioctl_dout", host_word_t'(ioctl_dout),
					host_word_t'(exp_dl_data.pop_front()));
			end
			wr_count++;
		end
	end

	////////////////////////////////////////
	// scenario sequence
	////////////////////////////////////////

	initial begin
		host_word_t cfg;
		host_word_t w;
		joystick_t  joy;
		status_t    st;
		logic [7:0] code;
		logic [7:0] idx;
		file_ext_t  ext;
		int         k;
		int         set_count;
		int         i;

		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		lfsr_state = 32'h0dd25855;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		wr_count   = 0;
		exp_key    = '0;
		set_count  = 0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		step();

		check_word("ioctl_download", host_word_t'(ioctl_download), '0);
		check_word("ioctl_wr", host_word_t'(ioctl_wr), '0);
		check_key("ps2_key", ps2_key, '0);
		check_word("io_dout", io_dout, '0);
		check_status("status", status, '0);
		check_joystick("joystick_0", joystick_0, '0);
		check_joystick("joystick_1", joystick_1, '0);

		// register writes
		repeat (4) begin
			cfg = host_word_t'(rand_bits(16));
			tx_words.delete();
			tx_words.push_back(cfg);
			run_cmd(cmd_config);
			check_word("buttons", host_word_t'(buttons), host_word_t'(cfg[1:0]));
			check_word("forced_scandoubler", host_word_t'(forced_scandoubler), host_word_t'(cfg[4]));
			check_word("direct_video", host_word_t'(direct_video), host_word_t'(cfg[10]));

			joy = joystick_t'(rand_bits(32));
			tx_words.delete();
			tx_words.push_back(joy[15:0]);
			tx_words.push_back(joy[31:16]);
			run_cmd(cmd_joy0);
			check_joystick("joystick_0", joystick_0, joy);

			joy = joystick_t'(rand_bits(32));
			tx_words.delete();
			tx_words.push_back(joy[15:0]);
			tx_words.push_back(joy[31:16]);
			run_cmd(cmd_joy1);
			check_joystick("joystick_1", joystick_1, joy);

			st = rand_bits(64);
			tx_words.delete();
			for (i = 0; i < 4; i++) tx_words.push_back(st[16*i +: 16]);
			run_cmd(cmd_status);
			check_status("status", status, st);
		end

		// status request, the count wraps after 16 requests
		repeat (2) begin
			k = 1 + int'(rand_bits(5));
			repeat (k) begin
				st         = rand_bits(64);
				status_in  = st;
				status_set = 1'b1;
				step();
				status_set = 1'b0;
				step();
			end
			set_count += k;
			tx_words.delete();
			repeat (4) tx_words.push_back('0);
			run_cmd(cmd_status_req);
			check_word("io_dout", rx_words[0], {8'h00, req_tag, set_count[3:0]});
			for (i = 1; i <= 4; i++) check_word("io_dout", rx_words[i], st[16*(i-1) +: 16]);
		end

		// keyboard
		repeat (4) begin
			code = 8'(rand_bits(8));
			queue_bytes({56'h0, code}, 1);
			key_command();
			queue_bytes({48'h0, 8'hF0, code}, 2);
			key_command();
			queue_bytes({48'h0, 8'hE0, code}, 2);
			key_command();
			queue_bytes({40'h0, 8'hE0, 8'hF0, code}, 3);
			key_command();
		end
		queue_bytes(64'hE012E07C, 4);
		key_command();
		queue_bytes(64'hE0F07CE0F012, 6);
		key_command();
		queue_bytes(64'hE11477E1F014F077, 8);
		key_command();
		queue_bytes(64'h1C, 1);
		tx_words.push_back({skip_marker, 8'h00});
		tx_words.push_back(16'h0032);
		key_command();

		// download
		ext = file_ext_t'(rand_bits(32));
		idx = 8'(rand_bits(8));
		tx_words.delete();
		tx_words.push_back(ext[31:16]);
		tx_words.push_back(ext[15:0]);
		run_cmd(cmd_file_info);
		tx_words.delete();
		tx_words.push_back({8'h00, idx});
		run_cmd(cmd_file_index);
		tx_words.delete();
		tx_words.push_back(16'h0001);
		run_cmd(cmd_file_tx);
		wait_download(1'b1);

		wr_count = 0;
		tx_words.delete();
		repeat (dl_words) begin
			w = host_word_t'(rand_bits(16));
			tx_words.push_back(w);
			exp_dl_data.push_back(w[7:0]);
		end
		run_cmd(cmd_file_data);
		ioctl_wait = 1'b0;

		tx_words.delete();
		tx_words.push_back(16'h0000);
		run_cmd(cmd_file_tx);
		wait_download(1'b0);
		check_addr("ioctl_addr", ioctl_addr, ioctl_addr_t'(dl_words * (data_width / 8)));
		check_word("ioctl_index", host_word_t'(ioctl_index), host_word_t'(idx));
		check_word("ioctl_file_ext", ioctl_file_ext[31:16], ext[31:16]);
		check_word("ioctl_file_ext", ioctl_file_ext[15:0], ext[15:0]);
		if (wr_count != dl_words || exp_dl_data.size() != 0) begin
			errors++;
			$display("Download monitor saw %0d writes for %0d data words", wr_count, dl_words);
		end

		finish_run();
	end

endmodule

//--- rtl/host_io_top.sv
// command side of the host to core bridge, instance this in the core's top level
`timescale 1ns/100ps

module host_io_top
	import host_proto_pkg::*;
	import user_io_pkg::*;
#(
	parameter int ioctl_data_width = 8
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// host bus
	input  logic                        io_enable,
	input  logic                        io_strobe,
	input  host_word_t                  io_din,
	output host_word_t                  io_dout,
	output logic                        io_wait,

	// configuration and inputs
	output logic [1:0]                  buttons,
	output logic                        forced_scandoubler,
	output logic                        direct_video,
	output joystick_t                   joystick_0,
	output joystick_t                   joystick_1,
	output status_t                     status,
	input  status_t                     status_in,
	input  logic                        status_set,
	output ps2_key_t                    ps2_key,

	// download
	output logic                        ioctl_download,
	output logic [7:0]                  ioctl_index,
	output file_ext_t                   ioctl_file_ext,
	output ioctl_addr_t                 ioctl_addr,
	output logic [ioctl_data_width-1:0] ioctl_dout,
	output logic                        ioctl_wr,
	input  logic                        ioctl_wait
);

	logic       cmd_strobe;
	logic       data_strobe;
	logic       cmd_done;
	host_word_t cmd;
	word_idx_t  word_idx;

	// core back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	host_cmd_framer host_cmd_framer_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe),
		.cmd         (cmd),
		.word_idx    (word_idx),
		.cmd_done    (cmd_done)
	);

	input_regs input_regs_inst (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_din             (io_din),
		.cmd_strobe         (cmd_strobe),
		.data_strobe        (data_strobe),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	ps2_key_decoder ps2_key_decoder_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_din      (io_din),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe),
		.cmd         (cmd),
		.cmd_done    (cmd_done),
		.ps2_key     (ps2_key)
	);

	file_download #(
		.ioctl_data_width (ioctl_data_width)
	) file_download_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.io_din         (io_din),
		.cmd_strobe     (cmd_strobe),
		.data_strobe    (data_strobe),
		.cmd            (cmd),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr)
	);

endmodule

//--- rtl/file_download.sv
// file transfer from the host, drives the core's download strobe, address and data
`timescale 1ns/100ps

module file_download
	import host_proto_pkg::*;
	import user_io_pkg::*;
#(
	parameter int ioctl_data_width = 8
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  host_word_t                  io_din,
	input  logic                        cmd_strobe,
	input  logic                        data_strobe,
	input  host_word_t                  cmd,
	output logic                        ioctl_download,
	output logic [7:0]                  ioctl_index,
	output file_ext_t                   ioctl_file_ext,
	output ioctl_addr_t                 ioctl_addr,
	output logic [ioctl_data_width-1:0] ioctl_dout,
	output logic                        ioctl_wr
);

	// bytes per data word
	localparam int addr_step = ioctl_data_width / 8;

	logic [1:0]  info_cnt;
	logic        wr_pend;
	ioctl_addr_t addr;

	////////////////////////////////////////
	// control state
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info_cnt       <= '0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
		end else begin
			// write pulse trails the data word by one cycle
			ioctl_wr <= wr_pend;
			wr_pend  <= data_strobe && cmd == cmd_file_data;

			if (cmd_strobe) info_cnt <= '0;
			else if (data_strobe && cmd == cmd_file_info && !info_cnt[1])
				info_cnt <= info_cnt + 1'b1;

			if (data_strobe && cmd == cmd_file_tx)
				ioctl_download <= io_din[7:0] != 8'h00;
		end
	end

	////////////////////////////////////////
	// address and payload
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (data_strobe) begin
			case (cmd)
				cmd_file_info: begin
					// extension arrives high half first
					if (info_cnt == 2'd0) ioctl_file_ext[31:16] <= io_din;
					if (info_cnt == 2'd1) ioctl_file_ext[15:0] <= io_din;
				end
				cmd_file_index: ioctl_index <= io_din[7:0];
				cmd_file_tx: begin
					if (io_din[7:0] != 8'h00) addr <= '0;
					else ioctl_addr <= addr;
				end
				cmd_file_data: begin
					ioctl_addr <= addr;
					ioctl_dout <= io_din[ioctl_data_width-1:0];
					addr       <= addr + ioctl_addr_t'(addr_step);
				end
				default: ;
			endcase
		end
	end

	// one write per data word, the host paces words with io_wait
	assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr);

endmodule

//--- rtl/ps2_key_decoder.sv
// keyboard scan byte collector that publishes one key event per keyboard command
`timescale 1ns/100ps

module ps2_key_decoder
	import host_proto_pkg::*;
	import user_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  host_word_t io_din,
	input  logic       cmd_strobe,
	input  logic       data_strobe,
	input  host_word_t cmd,
	input  logic       cmd_done,
	output ps2_key_t   ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_body;

	////////////////////////////////////////
	// event decode from the raw bytes
	////////////////////////////////////////

	// F0 in front of the newest byte marks a release
	assign pressed  = raw[15:8] != 8'hF0;
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		key_body = {pressed, extended, raw[7:0]};
		// print screen and pause send longer sequences
		case (raw)
			32'hE012E07C: key_body = 10'h37C;
			32'h7CE0F012: key_body = 10'h17C;
			32'hF014F077: key_body = 10'h377;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// byte collection
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cmd_strobe && io_din == cmd_keyboard) begin
			raw <= '0;
		end else if (data_strobe && cmd == cmd_keyboard && !skip
			&& io_din[15:8] != skip_marker) begin
			raw <= {raw[23:0], io_din[7:0]};
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (cmd_strobe && io_din == cmd_keyboard) skip <= 1'b0;
			else if (data_strobe && cmd == cmd_keyboard && io_din[15:8] == skip_marker)
				skip <= 1'b1;

			// a skipped command leaves the last event in place
			if (cmd_done && cmd == cmd_keyboard && !skip)
				ps2_key <= {~ps2_key[10], key_body};
		end
	end

endmodule

//--- rtl/input_regs.sv
// configuration, joystick and status registers plus the host readback word
`timescale 1ns/100ps

module input_regs
	import host_proto_pkg::*;
	import user_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  host_word_t io_din,
	input  logic       cmd_strobe,
	input  logic       data_strobe,
	input  host_word_t cmd,
	input  word_idx_t  word_idx,
	input  status_t    status_in,
	input  logic       status_set,
	output host_word_t io_dout,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output joystick_t  joystick_0,
	output joystick_t  joystick_1,
	output status_t    status
);

	host_word_t cfg;
	logic       status_set_q;
	logic [3:0] req_cnt;
	status_t    status_req;

	// bits of the configuration word used by the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////////////////
	// register writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (data_strobe) begin
			case (cmd)
				cmd_config: cfg <= io_din;
				cmd_joy0: begin
					if (word_idx == word_idx_t'(1)) joystick_0[15:0] <= io_din;
					else joystick_0[31:16] <= io_din;
				end
				cmd_joy1: begin
					if (word_idx == word_idx_t'(1)) joystick_1[15:0] <= io_din;
					else joystick_1[31:16] <= io_din;
				end
				cmd_status: begin
					case (word_idx)
						word_idx_t'(1): status[15:0]  <= io_din;
						word_idx_t'(2): status[31:16] <= io_din;
						word_idx_t'(3): status[47:32] <= io_din;
						word_idx_t'(4): status[63:48] <= io_din;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// status set request from the core
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) req_cnt <= req_cnt + 1'b1;
		end
	end

	// value the host fetches with the next request command
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q) status_req <= status_in;
	end

	////////////////////////////////////////
	// readback
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (cmd_strobe) begin
			// tag and count tell the host how many requests it missed
			io_dout <= (io_din == cmd_status_req) ? {8'h00, req_tag, req_cnt} : '0;
		end else if (data_strobe) begin
			io_dout <= '0;
			if (cmd == cmd_status_req) begin
				case (word_idx)
					word_idx_t'(1): io_dout <= status_req[15:0];
					word_idx_t'(2): io_dout <= status_req[31:16];
					word_idx_t'(3): io_dout <= status_req[47:32];
					word_idx_t'(4): io_dout <= status_req[63:48];
					default: ;
				endcase
			end
		end
	end

	// readback holds from one strobe to the next while the frame is open
	assert property (@(posedge clk_sys) disable iff (reset)
		io_enable && !cmd_strobe && !data_strobe |=> $stable(io_dout));

endmodule

//--- rtl/host_cmd_framer.sv
// command framer for the host bus, turns enable and strobes into command and data events
`timescale 1ns/100ps

module host_cmd_framer
	import host_proto_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  host_word_t io_din,
	output logic       cmd_strobe,
	output logic       data_strobe,
	output host_word_t cmd,
	output word_idx_t  word_idx,
	output logic       cmd_done
);

	logic has_cmd;
	logic enable_q;

	// first strobe inside a frame is the code, every later one is data
	assign cmd_strobe  = io_enable & io_strobe & ~has_cmd;
	assign data_strobe = io_enable & io_strobe & has_cmd;

	// first low cycle of the enable, cmd still holds the finished command here
	assign cmd_done = enable_q & ~io_enable;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			enable_q <= 1'b0;
			has_cmd  <= 1'b0;
			cmd      <= '0;
			word_idx <= '0;
		end else begin
			enable_q <= io_enable;
			if (!io_enable) begin
				has_cmd  <= 1'b0;
				cmd      <= '0;
				word_idx <= '0;
			end else if (cmd_strobe) begin
				has_cmd  <= 1'b1;
				cmd      <= io_din;
				word_idx <= word_idx_t'(1);
			end else if (data_strobe && word_idx != '1) begin
				// saturate so long transfers keep a stable index
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// every data word reaches the consumers with a valid index
	assert property (@(posedge clk_sys) disable iff (reset)
		data_strobe |-> word_idx != '0);

endmodule

//--- rtl/user_io_pkg.sv
// result types handed to the core, imported by the blocks that produce them
package user_io_pkg;

	////////////////////////////////////////
	// input state
	////////////////////////////////////////

	// digital joystick, one bit per button or direction
	typedef logic [31:0] joystick_t;

	// core status bits as set from the menu
	typedef logic [63:0] status_t;

	////////////////////////////////////////
	// keyboard
	////////////////////////////////////////

	// 10 toggles per event, 9 pressed, 8 extended, 7..0 key code
	typedef logic [10:0] ps2_key_t;

	////////////////////////////////////////
	// file download
	////////////////////////////////////////

	// byte address of the current download word
	typedef logic [26:0] ioctl_addr_t;

	// file extension as four characters
	typedef logic [31:0] file_ext_t;

endpackage

//--- rtl/host_proto_pkg.sv
// host bus protocol definitions, imported by every block that decodes host commands
package host_proto_pkg;

	////////////////////////////////////////
	// bus word and word position
	////////////////////////////////////////

	// one 16-bit word on the host bus
	typedef logic [15:0] host_word_t;

	// data word position, 1 is the first word after the command code
	typedef logic [9:0] word_idx_t;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	localparam host_word_t cmd_config     = 16'h0001;
	localparam host_word_t cmd_joy0       = 16'h0002;
	localparam host_word_t cmd_joy1       = 16'h0003;
	localparam host_word_t cmd_keyboard   = 16'h0005;
	localparam host_word_t cmd_status     = 16'h001E;
	localparam host_word_t cmd_status_req = 16'h0029;

	// file transfer group
	localparam host_word_t cmd_file_tx    = 16'h0053;
	localparam host_word_t cmd_file_data  = 16'h0054;
	localparam host_word_t cmd_file_index = 16'h0055;
	localparam host_word_t cmd_file_info  = 16'h0056;

	// upper nibble of the first status request answer
	localparam logic [3:0] req_tag = 4'hA;

	// upper byte of a keyboard word that carries no scan code
	localparam logic [7:0] skip_marker = 8'hFF;

endpackage
